// ==== hw/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;    // data, instruction or pc
    typedef logic [4:0]  reg_id_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  alu_op_t;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;

    // funct field under OP_SPECIAL
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_SLTU = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_LUI  = 4'd9;

endpackage

// ==== hw/instr_queue.sv ====
`timescale 1ns/10ps

module instr_queue import core_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  Clk,
    input  logic  Myreset,
    input  logic  instr_valid_i,
    input  word_t instr_i,
    output logic  head_valid_o,
    output word_t head_instr_o,
    output logic  credit_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;   // depth need not be 2^n
    endfunction

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign pop  = (count != '0);    // decode never stalls
    // a push into a full queue breaks the credit rule and is dropped
    assign push = instr_valid_i && !full;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= instr_i;
        end
    end

    assign head_valid_o = pop;
    assign head_instr_o = mem[rd_ptr];
    assign credit_o     = pop;  // one credit back per entry popped

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import core_pkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic    Clk,
    input  logic    Myreset,
    input  logic    head_valid_i,
    input  word_t   head_instr_i,
    output reg_id_t rs_id_o,
    output reg_id_t rt_id_o,
    input  word_t   rs_data_i,
    input  word_t   rt_data_i,
    input  word_t   alu_now_i,
    input  logic    e_valid_i,
    input  logic    e_wen_i,
    input  reg_id_t e_dest_i,
    input  word_t   e_result_i,
    output logic    d_valid_o,
    output word_t   d_pc_o,
    output alu_op_t d_alu_op_o,
    output word_t   d_op_a_o,
    output word_t   d_op_b_o,
    output shamt_t  d_shamt_o,
    output reg_id_t d_dest_o,
    output logic    d_wen_o
);

    opcode_t     opcode;
    funct_t      funct;
    reg_id_t     rs;
    reg_id_t     rt;
    reg_id_t     rd;
    shamt_t      shamt;
    logic [15:0] imm;
    alu_op_t     alu_op;
    logic        known;
    logic        r_type;
    logic        sign_ext;
    word_t       imm_ext;
    reg_id_t     dest;
    word_t       rs_val;
    word_t       rt_val;
    word_t       pc_q;

    assign opcode = head_instr_i[31:26];
    assign rs     = head_instr_i[25:21];
    assign rt     = head_instr_i[20:16];
    assign rd     = head_instr_i[15:11];
    assign shamt  = head_instr_i[10:6];
    assign funct  = head_instr_i[5:0];
    assign imm    = head_instr_i[15:0];

    always_comb begin
        alu_op   = ALU_ADD;
        known    = 1'b1;
        r_type   = 1'b0;
        sign_ext = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                r_type = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    default: known  = 1'b0;
                endcase
            end
            OP_ADDIU: sign_ext = 1'b1;
            OP_SLTI: begin
                alu_op   = ALU_SLT;
                sign_ext = 1'b1;
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: known  = 1'b0;    // retires as a no-op
        endcase
    end

    assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};
    assign dest    = r_type ? rd : rt;
    assign rs_id_o = rs;
    assign rt_id_o = rt;

    // youngest producer wins, r0 never matches since its wen is low
    function automatic word_t forward(input reg_id_t id, input word_t rf_val);
        if (d_valid_o && d_wen_o && (d_dest_o == id)) begin
            return alu_now_i;
        end
        if (e_valid_i && e_wen_i && (e_dest_i == id)) begin
            return e_result_i;
        end
        return rf_val;
    endfunction

    assign rs_val = forward(rs, rs_data_i);
    assign rt_val = forward(rt, rt_data_i);

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            pc_q      <= RESET_PC;
            d_valid_o <= 1'b0;
            d_wen_o   <= 1'b0;
        end else begin
            d_valid_o <= head_valid_i;
            d_wen_o   <= head_valid_i && known && (dest != '0);
            if (head_valid_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge Clk) begin
        d_pc_o     <= pc_q;
        d_alu_op_o <= alu_op;
        d_op_a_o   <= rs_val;
        d_op_b_o   <= r_type ? rt_val : imm_ext;
        d_shamt_o  <= shamt;
        d_dest_o   <= dest;
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import core_pkg::*; (
    input  logic    Clk,
    input  logic    Myreset,
    input  logic    d_valid_i,
    input  word_t   d_pc_i,
    input  alu_op_t d_alu_op_i,
    input  word_t   d_op_a_i,
    input  word_t   d_op_b_i,
    input  shamt_t  d_shamt_i,
    input  reg_id_t d_dest_i,
    input  logic    d_wen_i,
    output word_t   alu_now_o,
    output logic    e_valid_o,
    output word_t   e_pc_o,
    output reg_id_t e_dest_o,
    output logic    e_wen_o,
    output word_t   e_result_o
);

    // also feeds decode forwarding in the same cycle
    always_comb begin
        case (d_alu_op_i)
            ALU_ADD:  alu_now_o = d_op_a_i + d_op_b_i;
            ALU_SUB:  alu_now_o = d_op_a_i - d_op_b_i;
            ALU_AND:  alu_now_o = d_op_a_i & d_op_b_i;
            ALU_OR:   alu_now_o = d_op_a_i | d_op_b_i;
            ALU_XOR:  alu_now_o = d_op_a_i ^ d_op_b_i;
            ALU_SLT:  alu_now_o = {31'b0, $signed(d_op_a_i) < $signed(d_op_b_i)};
            ALU_SLTU: alu_now_o = {31'b0, d_op_a_i < d_op_b_i};
            ALU_SLL:  alu_now_o = d_op_b_i << d_shamt_i;
            ALU_SRL:  alu_now_o = d_op_b_i >> d_shamt_i;   // logical
            ALU_LUI:  alu_now_o = d_op_b_i << 16;
            default:  alu_now_o = '0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            e_valid_o <= 1'b0;
            e_wen_o   <= 1'b0;
        end else begin
            e_valid_o <= d_valid_i;
            e_wen_o   <= d_valid_i && d_wen_i;
        end
    end

    always_ff @(posedge Clk) begin
        e_pc_o     <= d_pc_i;
        e_dest_o   <= d_dest_i;
        e_result_o <= alu_now_o;
    end

endmodule

// ==== hw/result_stage.sv ====
`timescale 1ns/10ps

module result_stage import core_pkg::*; (
    input  logic       Clk,
    input  logic       Myreset,
    input  logic       e_valid_i,
    input  word_t      e_pc_i,
    input  reg_id_t    e_dest_i,
    input  logic       e_wen_i,
    input  word_t      e_result_i,
    input  reg_id_t    rs_id_i,
    input  reg_id_t    rt_id_i,
    output word_t      rs_data_o,
    output word_t      rt_data_o,
    output logic       debug_wb_valid_o,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_id_t    debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    word_t rf [1:31];   // r0 is hardwired
    logic  wb_wen;

    // written on the same edge the write-back register loads
    always_ff @(posedge Clk) begin
        if (e_valid_i && e_wen_i) begin
            rf[e_dest_i] <= e_result_i;    // e_wen_i is never set for r0
        end
    end

    assign rs_data_o = (rs_id_i == '0) ? '0 : rf[rs_id_i];
    assign rt_data_o = (rt_id_i == '0) ? '0 : rf[rt_id_i];

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            debug_wb_valid_o <= 1'b0;
            wb_wen           <= 1'b0;
        end else begin
            debug_wb_valid_o <= e_valid_i;
            wb_wen           <= e_valid_i && e_wen_i;
        end
    end

    always_ff @(posedge Clk) begin
        debug_wb_pc_o       <= e_pc_i;
        debug_wb_rf_wnum_o  <= e_dest_i;
        debug_wb_rf_wdata_o <= e_result_i;
    end

    // full word or nothing
    assign debug_wb_rf_wen_o = wb_wen ? 4'b1111 : 4'b0000;

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/10ps

module core_top import core_pkg::*; #(
    parameter int    QUEUE_DEPTH = 4,
    parameter word_t RESET_PC    = 32'hBFC0_0000
) (
    input  logic       Clk,
    input  logic       Myreset,
    input  logic       instr_valid_i,
    input  word_t      instr_i,
    output logic       credit_o,
    output logic       debug_wb_valid_o,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_id_t    debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    logic    head_valid;
    word_t   head_instr;
    reg_id_t rs_id;
    reg_id_t rt_id;
    word_t   rs_data;
    word_t   rt_data;
    word_t   alu_now;

    logic    d_valid;
    word_t   d_pc;
    alu_op_t d_alu_op;
    word_t   d_op_a;
    word_t   d_op_b;
    shamt_t  d_shamt;
    reg_id_t d_dest;
    logic    d_wen;

    logic    e_valid;
    word_t   e_pc;
    reg_id_t e_dest;
    logic    e_wen;
    word_t   e_result;

    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .Clk(Clk), .Myreset(Myreset),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .head_valid_o(head_valid), .head_instr_o(head_instr),
        .credit_o(credit_o)
    );

    decode_stage #(.RESET_PC(RESET_PC)) u_decode (
        .Clk(Clk), .Myreset(Myreset),
        .head_valid_i(head_valid), .head_instr_i(head_instr),
        .rs_id_o(rs_id), .rt_id_o(rt_id), .rs_data_i(rs_data), .rt_data_i(rt_data),
        .alu_now_i(alu_now),
        .e_valid_i(e_valid), .e_wen_i(e_wen), .e_dest_i(e_dest), .e_result_i(e_result),
        .d_valid_o(d_valid), .d_pc_o(d_pc), .d_alu_op_o(d_alu_op),
        .d_op_a_o(d_op_a), .d_op_b_o(d_op_b), .d_shamt_o(d_shamt),
        .d_dest_o(d_dest), .d_wen_o(d_wen)
    );

    execute_stage u_execute (
        .Clk(Clk), .Myreset(Myreset),
        .d_valid_i(d_valid), .d_pc_i(d_pc), .d_alu_op_i(d_alu_op),
        .d_op_a_i(d_op_a), .d_op_b_i(d_op_b), .d_shamt_i(d_shamt),
        .d_dest_i(d_dest), .d_wen_i(d_wen),
        .alu_now_o(alu_now),
        .e_valid_o(e_valid), .e_pc_o(e_pc), .e_dest_o(e_dest),
        .e_wen_o(e_wen), .e_result_o(e_result)
    );

    result_stage u_result (
        .Clk(Clk), .Myreset(Myreset),
        .e_valid_i(e_valid), .e_pc_i(e_pc), .e_dest_i(e_dest),
        .e_wen_i(e_wen), .e_result_i(e_result),
        .rs_id_i(rs_id), .rt_id_i(rt_id), .rs_data_o(rs_data), .rt_data_o(rt_data),
        .debug_wb_valid_o(debug_wb_valid_o), .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_rf_wen_o(debug_wb_rf_wen_o), .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic Clk,
    output logic Myreset
);

    initial begin
        Clk = 1'b0;
        forever #(PERIOD_NS / 2) Clk = ~Clk;
    end

    initial begin
        Myreset = 1'b1;
        repeat (RESET_CYCLES) @(posedge Clk);
        #1 Myreset = 1'b0;  // released just after the edge, like other inputs
    end

endmodule

// ==== testbench/core_props.sv ====
`timescale 1ns/10ps

module core_props #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                             Clk,
    input logic                             Myreset,
    input logic                             instr_valid_i,
    input logic                             full_i,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0] count_i,
    input logic                             credit_i
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [CNT_W-1:0] held;    // sent and not yet credited back

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            held <= '0;
        end else begin
            held <= held + CNT_W'(instr_valid_i) - CNT_W'(credit_i);
        end
    end

    // sender spent a credit it did not hold
    assert property (@(posedge Clk) disable iff (Myreset) full_i |-> !instr_valid_i)
        else $error("instruction pushed into a full queue");

    assert property (@(posedge Clk) disable iff (Myreset)
        held <= CNT_W'(QUEUE_DEPTH) && count_i == held)
        else $error("queue occupancy above its depth or out of step with credits");

    // nothing can be popped before the first push
    assert property (@(posedge Clk) $fell(Myreset) |-> !credit_i)
        else $error("credit returned in the first cycle after reset");

endmodule

bind instr_queue core_props #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_props (
    .Clk(Clk), .Myreset(Myreset), .instr_valid_i(instr_valid_i),
    .full_i(full), .count_i(count), .credit_i(credit_o)
);

// ==== testbench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb import core_pkg::*; ();

    localparam int    QUEUE_DEPTH = 4;
    localparam word_t RESET_PC    = 32'hBFC0_0000;
    localparam int    SEED        = 32'h7c16d7a9;
    localparam int    WAIT_LIMIT  = 200;   // cycles per wait loop

    logic       Clk;
    logic       Myreset;
    logic       instr_valid;
    word_t      instr;
    logic       credit;
    logic       wb_valid;
    word_t      wb_pc;
    logic [3:0] wb_wen;
    reg_id_t    wb_wnum;
    word_t      wb_wdata;

    word_t      model_rf [32];
    int         cycle = 0;
    int         sent_total = 0;
    int         credits_back = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    bit         timed_out = 1'b0;

    word_t      exp_pc [$];
    logic       exp_wen [$];
    reg_id_t    exp_wnum [$];
    word_t      exp_data [$];
    int         exp_cyc [$];
    word_t      act_pc [$];
    logic [3:0] act_wen [$];
    reg_id_t    act_wnum [$];
    word_t      act_data [$];
    int         act_cyc [$];
    int         act_rd = 0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clk (.Clk(Clk), .Myreset(Myreset));

    core_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .RESET_PC(RESET_PC)) UUT (
        .Clk(Clk), .Myreset(Myreset),
        .instr_valid_i(instr_valid), .instr_i(instr), .credit_o(credit),
        .debug_wb_valid_o(wb_valid), .debug_wb_pc_o(wb_pc),
        .debug_wb_rf_wen_o(wb_wen), .debug_wb_rf_wnum_o(wb_wnum),
        .debug_wb_rf_wdata_o(wb_wdata)
    );

    always @(posedge Clk) begin
        cycle <= cycle + 1;
    end

    // outputs are settled mid-cycle
    always @(negedge Clk) begin
        if (!Myreset && credit) begin
            credits_back = credits_back + 1;
        end
        if (!Myreset && wb_valid) begin
            act_pc.push_back(wb_pc);
            act_wen.push_back(wb_wen);
            act_wnum.push_back(wb_wnum);
            act_data.push_back(wb_wdata);
            act_cyc.push_back(cycle);
        end
    end

    task automatic check_word(input string sig, input word_t exp_v, input word_t act_v);
        checks++;
        assert (act_v === exp_v) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, sig, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_int(input string sig, input int exp_v, input int act_v);
        checks++;
        assert (act_v == exp_v) else begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, sig, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("test %-10s %s, %0d errors", name, (errors == start) ? "ok" : "failed",
                 errors - start);
    endtask

    function automatic word_t enc_r(funct_t fn, reg_id_t rd, reg_id_t rs, reg_id_t rt,
                                    shamt_t sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_id_t rt, reg_id_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // reference model for one instruction in program order
    task automatic expect_instr(input word_t code, input int sample_cyc);
        opcode_t     op;
        funct_t      fn;
        reg_id_t     rs;
        reg_id_t     rt;
        reg_id_t     dst;
        shamt_t      sa;
        logic [15:0] imm;
        word_t       a;
        word_t       b;
        word_t       res;
        logic        known;
        op    = code[31:26];
        rs    = code[25:21];
        rt    = code[20:16];
        sa    = code[10:6];
        fn    = code[5:0];
        imm   = code[15:0];
        a     = model_rf[rs];
        b     = model_rf[rt];
        known = 1'b1;
        dst   = rt;
        res   = '0;
        case (op)
            OP_SPECIAL: begin
                dst = code[15:11];
                case (fn)
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << sa;
                    FN_SRL:  res = b >> sa;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + {{16{imm[15]}}, imm};
            OP_SLTI:  res = ($signed(a) < $signed({{16{imm[15]}}, imm})) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & {16'h0, imm};
            OP_ORI:   res = a | {16'h0, imm};
            OP_XORI:  res = a ^ {16'h0, imm};
            OP_LUI:   res = {imm, 16'h0};
            default:  known = 1'b0;
        endcase
        if (known && dst != 5'd0) begin
            model_rf[dst] = res;
        end
        exp_pc.push_back(RESET_PC + word_t'(4 * sent_total));
        exp_wen.push_back(known && dst != 5'd0);
        exp_wnum.push_back(dst);
        exp_data.push_back(res);
        exp_cyc.push_back(sample_cyc);
    endtask

    // called and left 1 ns after a rising edge
    task automatic send_instr(input word_t code);
        int n;
        n = 0;
        if (timed_out) return;
        while (sent_total - credits_back >= QUEUE_DEPTH && n < WAIT_LIMIT) begin
            @(posedge Clk);
            #1;
            n++;
        end
        if (sent_total - credits_back >= QUEUE_DEPTH) begin
            report_timeout("credit for the next instruction");
            return;
        end
        instr_valid = 1'b1;
        instr = code;
        expect_instr(code, cycle + 1);
        sent_total++;
        @(posedge Clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic load_reg(input reg_id_t r, input word_t v);
        send_instr(enc_i(OP_LUI, r, 5'd0, v[31:16]));
        send_instr(enc_i(OP_ORI, r, r, v[15:0]));
    endtask

    task automatic drain_and_check(input bit check_latency);
        int n;
        n = 0;
        if (timed_out) return;
        while (act_pc.size() - act_rd < exp_pc.size() && n < WAIT_LIMIT) begin
            @(posedge Clk);
            #1;
            n++;
        end
        if (act_pc.size() - act_rd < exp_pc.size()) begin
            report_timeout("retirement of every sent instruction");
            return;
        end
        while (exp_pc.size() > 0) begin
            check_word("debug_wb_pc_o", exp_pc[0], act_pc[act_rd]);
            check_word("debug_wb_rf_wen_o", exp_wen[0] ? 32'hf : 32'h0,
                       word_t'(act_wen[act_rd]));
            if (exp_wen[0]) begin
                check_word("debug_wb_rf_wnum_o", word_t'(exp_wnum[0]), word_t'(act_wnum[act_rd]));
                check_word("debug_wb_rf_wdata_o", exp_data[0], act_data[act_rd]);
            end
            if (check_latency) begin
                check_int("retire latency", 3, act_cyc[act_rd] - exp_cyc[0]);
            end
            exp_pc.delete(0);
            exp_wen.delete(0);
            exp_wnum.delete(0);
            exp_data.delete(0);
            exp_cyc.delete(0);
            act_rd++;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (Myreset !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge Clk);
            #1;
            n++;
        end
        if (Myreset !== 1'b0) report_timeout("reset release");
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        repeat (4) begin
            @(negedge Clk);
            check_word("credit_o", 32'd0, word_t'(credit));
            check_word("debug_wb_valid_o", 32'd0, word_t'(wb_valid));
            check_word("debug_wb_rf_wen_o", 32'd0, word_t'(wb_wen));
        end
        @(posedge Clk);
        #1;
        finish_test("reset", start);
    endtask

    task automatic test_alu_ops();
        int          start;
        int          round;
        logic [15:0] imm;
        shamt_t      sa;
        start = errors;
        for (round = 0; round < 3; round++) begin
            imm = 16'($urandom());
            sa  = 5'($urandom());
            load_reg(5'd1, $urandom());
            load_reg(5'd2, $urandom());
            send_instr(enc_r(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_SUBU, 5'd4, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_AND,  5'd5, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_OR,   5'd6, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_XOR,  5'd7, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_SLT,  5'd8, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_SLTU, 5'd9, 5'd1, 5'd2, 5'd0));
            send_instr(enc_r(FN_SLL, 5'd10, 5'd0, 5'd2, sa));
            send_instr(enc_r(FN_SRL, 5'd11, 5'd0, 5'd2, sa));
            send_instr(enc_i(OP_ADDIU, 5'd12, 5'd1, imm));
            send_instr(enc_i(OP_SLTI,  5'd13, 5'd1, imm));
            send_instr(enc_i(OP_ANDI,  5'd14, 5'd1, imm));
            send_instr(enc_i(OP_ORI,   5'd15, 5'd1, imm));
            send_instr(enc_i(OP_XORI,  5'd16, 5'd1, imm));
            send_instr(enc_i(OP_LUI,   5'd17, 5'd0, imm));
        end
        drain_and_check(1'b0);
        finish_test("alu_ops", start);
    endtask

    task automatic test_forwarding();
        int start;
        int i;
        start = errors;
        load_reg(5'd20, $urandom());
        send_instr(enc_i(OP_ADDIU, 5'd21, 5'd20, 16'($urandom())));
        for (i = 0; i < 6; i++) begin
            send_instr(enc_i(OP_ADDIU, 5'd20, 5'd20, 16'($urandom())));
            send_instr(enc_r(FN_ADDU, 5'd21, 5'd20, 5'd21, 5'd0));
            send_instr(enc_r(FN_ADDU, 5'd20, 5'd21, 5'd20, 5'd0));   // distances 1 and 2
        end
        send_instr(enc_r(FN_SUBU, 5'd22, 5'd20, 5'd21, 5'd0));
        send_instr(enc_i(OP_ORI, 5'd23, 5'd0, 16'h0001));
        send_instr(enc_i(OP_ORI, 5'd24, 5'd0, 16'h0002));
        send_instr(enc_r(FN_ADDU, 5'd25, 5'd22, 5'd20, 5'd0));   // r22 from the register file
        drain_and_check(1'b0);
        finish_test("forwarding", start);
    endtask

    task automatic test_credits();
        int start;
        int sent0;
        int back0;
        int i;
        int n;
        start = errors;
        sent0 = sent_total;
        back0 = credits_back;
        for (i = 0; i < QUEUE_DEPTH; i++) begin
            send_instr(enc_i(OP_ADDIU, reg_id_t'(26 + i), 5'd1, 16'($urandom())));
        end
        n = 0;
        while (credits_back - back0 < QUEUE_DEPTH && n < WAIT_LIMIT) begin
            @(posedge Clk);
            #1;
            n++;
        end
        if (credits_back - back0 < QUEUE_DEPTH) report_timeout("return of all credits");
        drain_and_check(1'b0);
        repeat (3) @(posedge Clk);
        #1;
        check_int("credits returned", sent_total - sent0, credits_back - back0);
        finish_test("credits", start);
    endtask

    task automatic test_no_write();
        int start;
        start = errors;
        send_instr(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'h0055));
        send_instr(enc_r(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
        send_instr(enc_r(FN_OR, 5'd30, 5'd0, 5'd0, 5'd0));     // both r0 writes in flight
        send_instr(enc_i(6'h3f, 5'd3, 5'd1, 16'h1234));        // unknown opcode
        send_instr(enc_r(6'h3f, 5'd4, 5'd1, 5'd2, 5'd0));      // unknown funct
        send_instr(enc_i(OP_ADDIU, 5'd31, 5'd0, 16'h0000));
        send_instr(enc_r(FN_ADDU, 5'd29, 5'd0, 5'd4, 5'd0));   // r4 unchanged
        drain_and_check(1'b0);
        finish_test("no_write", start);
    endtask

    task automatic test_latency();
        int start;
        start = errors;
        send_instr(enc_i(OP_ORI, 5'd30, 5'd0, 16'h5a5a));
        drain_and_check(1'b1);
        finish_test("latency", start);
    endtask

    initial begin
        instr_valid = 1'b0;
        instr = '0;
        model_rf[0] = '0;   // r0 reads zero
        void'($urandom(SEED));
        wait_reset_release();
        test_reset();
        test_alu_ops();
        test_forwarding();
        test_credits();
        test_no_write();
        test_latency();
        repeat (4) @(posedge Clk);
        #1;
        check_int("retirements", sent_total, act_pc.size());
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/core_pkg.sv
hw/instr_queue.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
testbench/tb_clock_gen.sv
testbench/core_props.sv
testbench/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module core_tb \
    -f sim.f \
    -Mdir obj_dir -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
